// File: verilog/lcdPkg.sv
package lcdPkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////
	localparam int LCD_ADDR_W = 5;
	localparam int LCD_CHAR_W = 8;
	localparam int MENU_PAGE_W = 3;
	localparam int NIBBLE_W = 4;

	// Cell or RAM byte index, top row 0-15, bottom row 16-31
	typedef logic [LCD_ADDR_W-1:0] lcdAddr_t;
	// Character code, column in high nibble and row in low nibble
	typedef logic [LCD_CHAR_W-1:0] lcdChar_t;
	typedef logic [NIBBLE_W-1:0] charNibble_t;
	// Menu text or local page group
	typedef logic ramSel_t;
	typedef logic [MENU_PAGE_W-1:0] menuPage_t;

	localparam ramSel_t RAM_SEL_MENU = 1'b0;
	localparam ramSel_t RAM_SEL_LOCAL = 1'b1;

	// Row boundaries of the 2x16 display
	localparam lcdAddr_t TOP_FIRST = 5'd0;
	localparam lcdAddr_t TOP_LAST = 5'd15;
	localparam lcdAddr_t BOTTOM_FIRST = 5'd16;
	localparam lcdAddr_t BOTTOM_LAST = 5'd31;

	//////////////////////////////////////////////////
	// Port bundles
	//////////////////////////////////////////////////
	typedef struct packed {
		lcdAddr_t addr;
		lcdChar_t data;
		logic write;
	} lcdWrite_s;

	// Multi-page character RAM, synchronous read
	typedef struct packed {
		ramSel_t sel;
		menuPage_t page;
		lcdAddr_t addr;
		lcdChar_t wdata;
		logic write;
		logic clear;
	} ramPort_s;

endpackage

// File: verilog/menuPkg.sv
package menuPkg;

	//////////////////////////////////////////////////
	// Menu pages, value is the RAM page number
	//////////////////////////////////////////////////
	typedef enum logic [2:0] {
		MAIN_TITLE = 3'd0,
		SURE_TITLE = 3'd1,
		OPT_DISPLAY_LOCAL = 3'd2,
		OPT_MODIFY_LOCAL = 3'd3,
		OPT_CLEAR_LOCAL = 3'd4,
		OPT_YES = 3'd5,
		OPT_NO = 3'd6
	} menuOption_e;

	// Sequencer states
	typedef enum logic [4:0] {
		S_TITLE,
		S_OPTION,
		S_LOCAL,
		S_LITERAL,
		S_BUSY,
		S_SELECT,
		S_SHOW,
		S_POS_SEL,
		S_CHAR_SEL
	} seqState_e;

	typedef enum logic {
		SRC_RAM = 1'b0,
		SRC_LITERAL = 1'b1
	} refreshSrc_e;

	//////////////////////////////////////////////////
	// Job, input and editor bundles
	//////////////////////////////////////////////////
	// One refresh job, held stable while req is high
	typedef struct packed {
		lcdPkg::lcdAddr_t startAddr;
		lcdPkg::lcdAddr_t stopAddr;
		refreshSrc_e src;
		lcdPkg::lcdChar_t literal;
	} refreshReq_s;

	typedef struct packed {
		logic rotaryEvent;
		logic rotaryLeft;
		logic rotaryBtn;
		logic colLeftBtn;
		logic colRightBtn;
		logic menuBtn;
	} userInput_s;

	// Single cycle strobes
	typedef struct packed {
		logic home;
		logic posUp;
		logic posDown;
		logic rowUp;
		logic rowDown;
		logic colLeft;
		logic colRight;
	} editCmd_s;

endpackage

// File: verilog/lcdRefresher.sv
`timescale 1ns/1ps

module lcdRefresher (
	input logic clk,
	input logic reset,
	input logic req,
	input menuPkg::refreshReq_s refreshReq,
	input lcdPkg::lcdChar_t ramData,
	output logic ack,
	output lcdPkg::lcdWrite_s lcd,
	output lcdPkg::lcdAddr_t ramAddr
);
	import lcdPkg::*;
	import menuPkg::*;

	typedef enum logic [1:0] {
		R_IDLE,
		R_SETUP,
		R_WRITE,
		R_DONE
	} refState_e;

	refState_e state;
	// Current LCD cell
	lcdAddr_t lcdAddr;

	//////////////////////////////////////////////////
	// Handshake and byte walk
	//////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
			state <= R_IDLE;
		else
		begin
			case (state)
				R_IDLE:
					if (req)
						state <= R_SETUP;
				// Dropped req means abort, no more writes
				R_SETUP:
					state <= req ? R_WRITE : R_IDLE;
				R_WRITE:
					if (!req)
						state <= R_IDLE;
					else if (lcdAddr == refreshReq.stopAddr)
						state <= R_DONE;
					else
						state <= R_SETUP;
				// Hold ack until the sequencer lets go
				R_DONE:
					if (!req)
						state <= R_IDLE;
				default:
					state <= R_IDLE;
			endcase
		end
	end

	// Both pointers step after each write
	always_ff @(posedge clk)
	begin
		if (state == R_IDLE)
		begin
			lcdAddr <= refreshReq.startAddr;
			ramAddr <= '0;
		end
		else if (state == R_WRITE)
		begin
			lcdAddr <= lcdAddr + lcdAddr_t'(1);
			ramAddr <= ramAddr + lcdAddr_t'(1);
		end
	end

	assign ack = (state == R_DONE);

	// RAM data lands in the write cycle, one after setup
	always_comb
	begin
		lcd.addr = lcdAddr;
		lcd.data = (refreshReq.src == SRC_LITERAL) ? refreshReq.literal : ramData;
		lcd.write = (state == R_WRITE) && req;
	end

endmodule

// File: verilog/charEditor.sv
`timescale 1ns/1ps

module charEditor #(
	parameter lcdPkg::charNibble_t HOME_COLUMN = 4'd4,
	parameter lcdPkg::charNibble_t HOME_ROW = 4'd1
) (
	input logic clk,
	input logic reset,
	input menuPkg::editCmd_s editCmd,
	output lcdPkg::lcdAddr_t editPos,
	output lcdPkg::lcdChar_t editChar
);
	import lcdPkg::*;

	charNibble_t charColumn;
	charNibble_t charRow;
	// Next column after skip rules
	charNibble_t colPrev;
	charNibble_t colNext;

	//////////////////////////////////////////////////
	// Column skip rules
	//////////////////////////////////////////////////
	// Columns 0-1 and 8-9 hold no printable glyphs
	always_comb
	begin
		case (charColumn)
			4'h2:
				colPrev = 4'hF;
			4'hA:
				colPrev = 4'h7;
			default:
				colPrev = charColumn - charNibble_t'(1);
		endcase
		case (charColumn)
			4'h7:
				colNext = 4'hA;
			4'hF:
				colNext = 4'h2;
			default:
				colNext = charColumn + charNibble_t'(1);
		endcase
	end

	//////////////////////////////////////////////////
	// Position, row and column registers
	//////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset || editCmd.home)
		begin
			editPos <= '0;
			charColumn <= HOME_COLUMN;
			charRow <= HOME_ROW;
		end
		else
		begin
			// Position wraps over all 32 cells
			if (editCmd.posUp)
				editPos <= editPos + lcdAddr_t'(1);
			else if (editCmd.posDown)
				editPos <= editPos - lcdAddr_t'(1);
			// Row wraps modulo 16
			if (editCmd.rowUp)
				charRow <= charRow + charNibble_t'(1);
			else if (editCmd.rowDown)
				charRow <= charRow - charNibble_t'(1);
			if (editCmd.colLeft)
				charColumn <= colPrev;
			else if (editCmd.colRight)
				charColumn <= colNext;
		end
	end

	assign editChar = {charColumn, charRow};

endmodule

// File: verilog/menuSequencer.sv
`timescale 1ns/1ps

module menuSequencer (
	input logic clk,
	input logic reset,
	input menuPkg::userInput_s user,
	input logic ack,
	input lcdPkg::lcdAddr_t editPos,
	input lcdPkg::lcdChar_t editChar,
	output logic req,
	output menuPkg::refreshReq_s refreshReq,
	output menuPkg::editCmd_s editCmd,
	output lcdPkg::ramPort_s ramCtrl
);
	import lcdPkg::*;
	import menuPkg::*;

	seqState_e state;
	// Where to go once the running job acks
	seqState_e retState;
	menuOption_e option;
	menuOption_e nextOption;
	// RAM control registers
	ramSel_t ramSel;
	menuPage_t ramPage;
	lcdChar_t wdata;
	logic ramWrite;
	logic ramClear;
	// Job for the current launch state
	refreshReq_s job;
	ramSel_t jobSel;
	menuPage_t jobPage;
	seqState_e jobNext;
	logic posMode;
	logic charMode;
	logic charChange;

	//////////////////////////////////////////////////
	// Refresh job table
	//////////////////////////////////////////////////
	always_comb
	begin
		job.startAddr = TOP_FIRST;
		job.stopAddr = BOTTOM_LAST;
		job.src = SRC_RAM;
		job.literal = editChar;
		jobSel = RAM_SEL_LOCAL;
		jobPage = '0;
		jobNext = S_SELECT;
		case (state)
			// Title row, the YES/NO pair has its own
			S_TITLE:
			begin
				job.stopAddr = TOP_LAST;
				jobSel = RAM_SEL_MENU;
				jobPage = (option == OPT_YES || option == OPT_NO) ?
					menuPage_t'(SURE_TITLE) : menuPage_t'(MAIN_TITLE);
				jobNext = S_OPTION;
			end
			S_OPTION:
			begin
				job.startAddr = BOTTOM_FIRST;
				jobSel = RAM_SEL_MENU;
				jobPage = menuPage_t'(option);
			end
			// Whole local page
			S_LOCAL:
				jobNext = (option == OPT_MODIFY_LOCAL) ? S_POS_SEL : S_SHOW;
			// Single cell with the edited character
			S_LITERAL:
			begin
				job.startAddr = editPos;
				job.stopAddr = editPos;
				job.src = SRC_LITERAL;
				jobNext = S_CHAR_SEL;
			end
			default:
				jobNext = S_SELECT;
		endcase
	end

	// Main ring, rotary left is next
	always_comb
	begin
		case (option)
			OPT_DISPLAY_LOCAL:
				nextOption = user.rotaryLeft ? OPT_MODIFY_LOCAL : OPT_CLEAR_LOCAL;
			OPT_MODIFY_LOCAL:
				nextOption = user.rotaryLeft ? OPT_CLEAR_LOCAL : OPT_DISPLAY_LOCAL;
			OPT_CLEAR_LOCAL:
				nextOption = user.rotaryLeft ? OPT_DISPLAY_LOCAL : OPT_MODIFY_LOCAL;
			OPT_YES:
				nextOption = OPT_NO;
			OPT_NO:
				nextOption = OPT_YES;
			default:
				nextOption = OPT_DISPLAY_LOCAL;
		endcase
	end

	//////////////////////////////////////////////////
	// Editor strobes
	//////////////////////////////////////////////////
	// A rotary press wins over rotation and column buttons
	always_comb
	begin
		posMode = (state == S_POS_SEL) && !user.rotaryBtn;
		charMode = (state == S_CHAR_SEL) && !user.rotaryBtn;
		editCmd.home = user.menuBtn;
		editCmd.posUp = posMode && user.rotaryEvent && user.rotaryLeft;
		editCmd.posDown = posMode && user.rotaryEvent && !user.rotaryLeft;
		editCmd.rowUp = charMode && user.rotaryEvent && user.rotaryLeft;
		editCmd.rowDown = charMode && user.rotaryEvent && !user.rotaryLeft;
		editCmd.colLeft = charMode && !user.rotaryEvent && user.colLeftBtn;
		editCmd.colRight = charMode && !user.rotaryEvent && !user.colLeftBtn &&
			user.colRightBtn;
		charChange = editCmd.rowUp || editCmd.rowDown || editCmd.colLeft ||
			editCmd.colRight;
	end

	//////////////////////////////////////////////////
	// Menu state machine
	//////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		// Strobes last one cycle
		ramWrite <= 1'b0;
		ramClear <= 1'b0;
		// Menu button aborts whatever runs
		if (reset || user.menuBtn)
		begin
			state <= S_TITLE;
			retState <= S_SELECT;
			req <= 1'b0;
			option <= OPT_DISPLAY_LOCAL;
			ramSel <= RAM_SEL_MENU;
			ramPage <= '0;
		end
		else
		begin
			case (state)
				// Launch only once the last ack has gone
				S_TITLE, S_OPTION, S_LOCAL, S_LITERAL:
					if (!ack)
					begin
						refreshReq <= job;
						ramSel <= jobSel;
						ramPage <= jobPage;
						retState <= jobNext;
						req <= 1'b1;
						state <= S_BUSY;
					end
				S_BUSY:
					if (ack)
					begin
						req <= 1'b0;
						state <= retState;
					end
				S_SELECT:
					if (user.rotaryBtn)
					begin
						case (option)
							OPT_DISPLAY_LOCAL, OPT_MODIFY_LOCAL:
								state <= S_LOCAL;
							OPT_CLEAR_LOCAL:
							begin
								option <= OPT_YES;
								state <= S_TITLE;
							end
							// Confirmed clear of the local page
							OPT_YES:
							begin
								ramClear <= 1'b1;
								ramSel <= RAM_SEL_LOCAL;
								option <= OPT_DISPLAY_LOCAL;
								state <= S_TITLE;
							end
							default:
							begin
								option <= OPT_DISPLAY_LOCAL;
								state <= S_TITLE;
							end
						endcase
					end
					else if (user.rotaryEvent)
					begin
						option <= nextOption;
						state <= S_TITLE;
					end
				S_SHOW:
					if (user.rotaryBtn)
						state <= S_TITLE;
				// Position moves through editor strobes
				S_POS_SEL:
					if (user.rotaryBtn)
						state <= S_CHAR_SEL;
				S_CHAR_SEL:
					if (user.rotaryBtn)
					begin
						wdata <= editChar;
						ramWrite <= 1'b1;
						state <= S_POS_SEL;
					end
					else if (charChange)
						state <= S_LITERAL;
				default:
					state <= S_TITLE;
			endcase
		end
	end

	// Address comes from the refresher or the editor at the top
	assign ramCtrl = '{sel: ramSel, page: ramPage, addr: '0, wdata: wdata,
		write: ramWrite, clear: ramClear};

endmodule

// File: verilog/menuController.sv
`timescale 1ns/1ps

module menuController #(
	parameter lcdPkg::charNibble_t HOME_COLUMN = 4'd4,
	parameter lcdPkg::charNibble_t HOME_ROW = 4'd1
) (
	input logic clk,
	input logic reset,
	input menuPkg::userInput_s user,
	input lcdPkg::lcdChar_t ramData,
	output lcdPkg::lcdWrite_s lcd,
	output lcdPkg::ramPort_s ram
);
	import lcdPkg::*;
	import menuPkg::*;

	// Sequencer to refresher
	logic req;
	logic ack;
	refreshReq_s refreshReq;
	lcdAddr_t refAddr;
	// Sequencer and editor
	editCmd_s editCmd;
	lcdAddr_t editPos;
	lcdChar_t editChar;
	ramPort_s ramCtrl;

	//////////////////////////////////////////////////
	// Blocks
	//////////////////////////////////////////////////
	menuSequencer sequencer (
		.clk(clk),
		.reset(reset),
		.user(user),
		.ack(ack),
		.editPos(editPos),
		.editChar(editChar),
		.req(req),
		.refreshReq(refreshReq),
		.editCmd(editCmd),
		.ramCtrl(ramCtrl)
	);

	lcdRefresher refresher (
		.clk(clk),
		.reset(reset),
		.req(req),
		.refreshReq(refreshReq),
		.ramData(ramData),
		.ack(ack),
		.lcd(lcd),
		.ramAddr(refAddr)
	);

	charEditor #(
		.HOME_COLUMN(HOME_COLUMN),
		.HOME_ROW(HOME_ROW)
	) editor (
		.clk(clk),
		.reset(reset),
		.editCmd(editCmd),
		.editPos(editPos),
		.editChar(editChar)
	);

	// RAM write goes to the edit cell, reads follow the refresher
	always_comb
	begin
		ram = ramCtrl;
		ram.addr = ramCtrl.write ? editPos : refAddr;
	end

endmodule

// File: sim/tbClock.sv
`timescale 1ns/1ps

module tbClock (
	output logic clk,
	output logic reset
);
	// 100 ns period
	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;
	end

	// Reset held for the first 10 cycles
	initial
	begin
		reset <= 1'b1;
		repeat (10)
			@(posedge clk);
		reset <= 1'b0;
	end

endmodule

// File: sim/menuController_asserts.sv
`timescale 1ns/1ps

module menuControllerAsserts (
	input logic clk,
	input logic reset,
	input logic req,
	input logic ack,
	input lcdPkg::lcdWrite_s lcd,
	input lcdPkg::ramPort_s ram
);
	import lcdPkg::*;

	//////////////////////////////////////////////////
	// Refresher handshake
	//////////////////////////////////////////////////
	// Ack only rises while req is held
	ackFollowsReq: assert property (@(posedge clk) disable iff (reset)
		$rose(ack) |-> req)
		else $error("ack rose without a pending req");

	// Done phase is quiet, no LCD write and no new job
	noWriteInDone: assert property (@(posedge clk) disable iff (reset)
		ack |-> !lcd.write && !$rose(req))
		else $error("LCD write or new req during the done phase");

	//////////////////////////////////////////////////
	// RAM strobes
	//////////////////////////////////////////////////
	strobesExclusive: assert property (@(posedge clk) disable iff (reset)
		!(ram.write && ram.clear))
		else $error("RAM write and clear high together");

endmodule

bind menuController menuControllerAsserts asserts (
	.clk(clk),
	.reset(reset),
	.req(req),
	.ack(ack),
	.lcd(lcd),
	.ram(ram)
);

// File: sim/menuController_tb.sv
`timescale 1ns/1ps

module menuController_tb;
	import lcdPkg::*;
	import menuPkg::*;

	localparam int TRACE_DEPTH = 64;
	// Per expectation bound, in cycles
	localparam int WAIT_LIMIT = 300;
	// Longest gap inside one menu refresh is 6 cycles
	localparam int QUIET_CYCLES = 10;

	// Trace opcodes in bits 31:28
	localparam logic [3:0] OP_END = 4'h0;
	localparam logic [3:0] OP_INPUT = 4'h1;
	localparam logic [3:0] OP_MENU = 4'h2;
	localparam logic [3:0] OP_LOCAL = 4'h3;
	localparam logic [3:0] OP_WALK = 4'h4;
	localparam logic [3:0] OP_RAMWR = 4'h5;
	localparam logic [3:0] OP_CLEAR = 4'h6;
	localparam logic [3:0] OP_FILL = 4'h7;

	logic clk;
	logic reset;
	userInput_s user;
	lcdChar_t ramData;
	lcdWrite_s lcd;
	ramPort_s ram;

	logic [31:0] trace [TRACE_DEPTH];
	// Model RAM, menu pages and the local page
	lcdChar_t menuMem [8][32];
	lcdChar_t localMem [32];
	// Local page as the trace says it should be
	lcdChar_t expLocal [32];
	int valueErrors;
	int otherErrors;
	int watchdogCycles;

	tbClock clockGen (
		.clk(clk),
		.reset(reset)
	);

	menuController #(
		.HOME_COLUMN(4'd4),
		.HOME_ROW(4'd1)
	) UUT (
		.clk(clk),
		.reset(reset),
		.user(user),
		.ramData(ramData),
		.lcd(lcd),
		.ram(ram)
	);

	//////////////////////////////////////////////////
	// Model RAM, one cycle read latency
	//////////////////////////////////////////////////
	// Menu byte is page in the top three bits, byte index below
	initial
	begin
		for (int p = 0; p < 8; p++)
			for (int i = 0; i < 32; i++)
				menuMem[p][i] = {3'(p), 5'(i)};
		for (int i = 0; i < 32; i++)
		begin
			localMem[i] <= '0;
			expLocal[i] = '0;
		end
		ramData <= '0;
	end

	always @(posedge clk)
	begin
		if (ram.clear && ram.sel == RAM_SEL_LOCAL)
			for (int i = 0; i < 32; i++)
				localMem[i] <= '0;
		else if (ram.write && ram.sel == RAM_SEL_LOCAL)
			localMem[ram.addr] <= ram.wdata;
		ramData <= (ram.sel == RAM_SEL_LOCAL) ? localMem[ram.addr] :
			menuMem[ram.page][ram.addr];
	end

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////
	task automatic checkLcd(input lcdWrite_s exp, input lcdWrite_s got, input bit withData);
		if (got.addr !== exp.addr)
		begin
			valueErrors++;
			$display("ERR lcd.addr expected 0x%h got 0x%h", exp.addr, got.addr);
		end
		if (withData && got.data !== exp.data)
		begin
			valueErrors++;
			$display("ERR lcd.data expected 0x%h got 0x%h", exp.data, got.data);
		end
	endtask

	// Address and data only matter for a write
	task automatic checkRam(input ramPort_s exp, input ramPort_s got);
		if (got.sel !== exp.sel)
		begin
			valueErrors++;
			$display("ERR ram.sel expected 0x%h got 0x%h", exp.sel, got.sel);
		end
		if (got.write !== exp.write || got.clear !== exp.clear)
		begin
			valueErrors++;
			$display("ERR ram.write/clear expected 0x%h got 0x%h",
				{exp.write, exp.clear}, {got.write, got.clear});
		end
		if (exp.write && got.addr !== exp.addr)
		begin
			valueErrors++;
			$display("ERR ram.addr expected 0x%h got 0x%h", exp.addr, got.addr);
		end
		if (exp.write && got.wdata !== exp.wdata)
		begin
			valueErrors++;
			$display("ERR ram.wdata expected 0x%h got 0x%h", exp.wdata, got.wdata);
		end
	endtask

	task automatic reportProblem(input string what);
		otherErrors++;
		$display("%s", what);
	endtask

	//////////////////////////////////////////////////
	// Waits, sampled on the falling edge
	//////////////////////////////////////////////////
	task automatic expectLcd(input lcdAddr_t addr, input lcdChar_t data, input bit withData);
		lcdWrite_s exp;
		int waited;
		exp.addr = addr;
		exp.data = data;
		exp.write = 1'b1;
		waited = 0;
		do
		begin
			@(negedge clk);
			waited++;
			if (ram.write || ram.clear)
				reportProblem("RAM strobe while an LCD write was expected");
		end while (!lcd.write && waited < WAIT_LIMIT);
		if (lcd.write)
			checkLcd(exp, lcd, withData);
		else
			reportProblem($sformatf("No LCD write to cell %0d arrived", addr));
	endtask

	task automatic expectRam(input ramPort_s exp);
		int waited;
		waited = 0;
		do
		begin
			@(negedge clk);
			waited++;
			if (lcd.write)
				reportProblem("LCD write while a RAM strobe was expected");
		end while (!(ram.write || ram.clear) && waited < WAIT_LIMIT);
		if (ram.write || ram.clear)
			checkRam(exp, ram);
		else
			reportProblem("Expected RAM strobe never came");
	endtask

	// End of refresh, nothing moves for a while
	task automatic waitQuiet();
		int quiet;
		int waited;
		quiet = 0;
		waited = 0;
		while (quiet < QUIET_CYCLES && waited < WAIT_LIMIT)
		begin
			@(negedge clk);
			waited++;
			quiet++;
			if (lcd.write)
			begin
				reportProblem($sformatf("Unexpected LCD write to cell %0d", lcd.addr));
				quiet = 0;
			end
			if (ram.write || ram.clear)
				reportProblem("Unexpected RAM strobe");
		end
	endtask

	task automatic driveInput(input userInput_s bits);
		@(posedge clk);
		user <= bits;
		@(posedge clk);
		user <= '0;
	endtask

	// Title row from one page, option row from another, both from byte 0 on
	task automatic expectMenu(input menuPage_t title, input menuPage_t option, input int count);
		lcdAddr_t addr;
		lcdAddr_t byteIdx;
		menuPage_t page;
		for (int i = 0; i < count; i++)
		begin
			addr = lcdAddr_t'(i);
			page = (i < 16) ? title : option;
			byteIdx = (i < 16) ? addr : addr - lcdAddr_t'(16);
			expectLcd(addr, {page, byteIdx}, 1'b1);
		end
	endtask

	task automatic expectLocal();
		for (int i = 0; i < 32; i++)
			expectLcd(lcdAddr_t'(i), expLocal[i], 1'b1);
	endtask

	// Repeated editor input, each gives one literal write
	task automatic walkChar(input logic [31:0] step);
		int count;
		count = int'(step[27:24]);
		for (int i = 1; i <= count; i++)
		begin
			waitQuiet();
			driveInput(userInput_s'(step[21:16]));
			expectLcd(lcdAddr_t'(step[12:8]), lcdChar_t'(step[7:0]), i == count);
		end
	endtask

	//////////////////////////////////////////////////
	// Trace runner
	//////////////////////////////////////////////////
	initial
	begin
		logic [31:0] step;
		ramPort_s expRam;
		int writes;
		user <= '0;
		valueErrors = 0;
		otherErrors = 0;
		writes = 0;
		watchdogCycles = 0;
		$readmemh("sim/menuTrace.txt", trace);
		for (int pc = 0; pc < TRACE_DEPTH; pc++)
		begin
			if ($isunknown(trace[pc]) || trace[pc][31:28] == OP_END)
				break;
			case (trace[pc][31:28])
				OP_MENU:
					writes += int'(trace[pc][21:16]);
				OP_LOCAL:
					writes += 32;
				OP_WALK:
					writes += int'(trace[pc][27:24]);
				default:
					writes += 0;
			endcase
		end
		watchdogCycles = 40 * writes + 2000;
		@(negedge reset);
		for (int pc = 0; pc < TRACE_DEPTH; pc++)
		begin
			step = trace[pc];
			if ($isunknown(step) || step[31:28] == OP_END)
				break;
			expRam = '0;
			expRam.sel = RAM_SEL_LOCAL;
			case (step[31:28])
				OP_INPUT:
				begin
					// Bit 8 presses into a running refresh
					if (!step[8])
						waitQuiet();
					driveInput(userInput_s'(step[5:0]));
				end
				OP_MENU:
					expectMenu(menuPage_t'(step[10:8]), menuPage_t'(step[2:0]),
						int'(step[21:16]));
				OP_LOCAL:
					expectLocal();
				OP_WALK:
					walkChar(step);
				OP_RAMWR:
				begin
					expRam.addr = lcdAddr_t'(step[12:8]);
					expRam.wdata = lcdChar_t'(step[7:0]);
					expRam.write = 1'b1;
					expectRam(expRam);
					expLocal[step[12:8]] = lcdChar_t'(step[7:0]);
				end
				OP_CLEAR:
				begin
					expRam.clear = 1'b1;
					expectRam(expRam);
					for (int i = 0; i < 32; i++)
						expLocal[i] = '0;
				end
				OP_FILL:
					for (int i = 0; i < 32; i++)
					begin
						localMem[i] <= lcdChar_t'(step[7:0]) + lcdChar_t'(i);
						expLocal[i] = lcdChar_t'(step[7:0]) + lcdChar_t'(i);
					end
				default:
					reportProblem($sformatf("Unknown trace step %h", step));
			endcase
		end
		waitQuiet();
		$display("Errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// Watchdog, sized from the trace
	initial
	begin
		wait (watchdogCycles > 0);
		repeat (watchdogCycles)
			@(posedge clk);
		$display("Watchdog expired after %0d cycles, the run hung", watchdogCycles);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: sim/menuTrace.txt
// Opcode in [31:28]: 1 input (bit 8 no wait, bits 5:0 user), 2 menu refresh (21:16 count,
// 10:8 title page, 2:0 option page), 3 local page, 4 char walk (27:24 count, 21:16 user,
// 12:8 cell, 7:0 last char), 5 RAM write (12:8 cell, 7:0 char), 6 clear, 7 fill base, 0 end
70000040 20200002
10000030 20200003
10000030 20200004
10000030 20200002
10000020 20200004
10000020 20200003
10000020 20200002
10000008 30000000
10000008 20200002
10000030 20200003
10000008 30000000
10000030 10000030
10000008 41300242
440202A2 41040272
460402F2 41020222
10000008 50000222
10000001 20200002
10000008 30000000
10000008 20200002
10000020 20200004
10000008 20200105
10000030 20200106
10000008 20200002
10000020 20200004
10000008 20200105
10000008 60000000 20200002
10000008 30000000
10000008 20200002
10000030 20050003
10000101 20200002
00000000

// File: vlog.f
verilog/lcdPkg.sv
verilog/menuPkg.sv
verilog/lcdRefresher.sv
verilog/charEditor.sv
verilog/menuSequencer.sv
verilog/menuController.sv
sim/tbClock.sv
sim/menuController_asserts.sv
sim/menuController_tb.sv

// File: run.sh
#!/bin/sh
# Build and run from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
	--top-module menuController_tb > build.log 2>&1 \
	&& ./obj_dir/VmenuController_tb > sim.log 2>&1 \
	|| echo "RESULT: FAIL" >> sim.log
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1
exit 0
